// File: rv_core.f
src/rv_isa_pkg.sv
src/core_bus_pkg.sv
src/stage_reg.sv
src/fetch_unit.sv
src/decode_unit.sv
src/execute_unit.sv
src/result_unit.sv
src/rv_core.sv
tb/clock_gen.sv
tb/axi_imem_model.sv
tb/rv_core_tb.sv

// File: src/core_bus_pkg.sv
package core_bus_pkg;

  typedef struct packed {
    logic [31:0] araddr;
    logic        arvalid;
    logic [3:0]  arid;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic [1:0]  arburst;
    logic        rready;
  } axi_ar_t;

  typedef struct packed {
    logic        arready;
    logic        rvalid;
    logic [63:0] rdata;
    logic [1:0]  rresp;
  } axi_r_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
  } fetch_pkt_t;

  typedef struct packed {
    logic [31:0]          pc;
    logic [31:0]          op_a;
    logic [31:0]          op_b;
    logic [31:0]          imm;
    logic [4:0]           rd;
    logic                 wen;
    rv_isa_pkg::alu_op_t  alu_op;
    rv_isa_pkg::br_cond_t br_cond;
    logic                 pred_taken;
    logic                 a_is_pc;
    logic                 b_is_imm;
  } issue_pkt_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] value;
    logic [4:0]  rd;
    logic        wen;
  } exec_pkt_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] value;
    logic        wen;
  } retire_t;

endpackage

// File: src/decode_unit.sv
`timescale 1ns/1ps

module decode_unit import rv_isa_pkg::*, core_bus_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        flush,
  input  logic        in_valid,
  output logic        in_ready,
  input  fetch_pkt_t  in,
  output logic        out_valid,
  input  logic        out_ready,
  output issue_pkt_t  out,
  output logic [4:0]  rs1_addr,
  output logic [4:0]  rs2_addr,
  input  logic [31:0] rs1_data,
  input  logic [31:0] rs2_data,
  input  logic        wb_valid,
  input  logic [4:0]  wb_rd
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [4:0]  rd;
  logic        alt;
  logic        use_rs1, use_rs2, wen;
  logic        a_is_pc, b_is_imm;
  logic [31:0] imm;
  alu_op_t     alu_sel, alu_op;
  br_cond_t    br_cond;
  logic [31:0] busy;        // one bit per register, x0 never set
  logic        last_valid;  // writer issued last cycle
  logic [4:0]  last_rd;
  logic        stall, issue;

  assign opcode   = in.inst[6:0];
  assign funct3   = in.inst[14:12];
  assign rd       = in.inst[11:7];
  assign rs1_addr = in.inst[19:15];
  assign rs2_addr = in.inst[24:20];
  assign alt      = in.inst[30] & ((opcode == op_reg) | (funct3 == f3_srl_sra));

  always_comb begin
    case (funct3)
      f3_add_sub: alu_sel = alt ? alu_sub : alu_add;
      f3_sll:     alu_sel = alu_sll;
      f3_slt:     alu_sel = alu_slt;
      f3_sltu:    alu_sel = alu_sltu;
      f3_xor:     alu_sel = alu_xor;
      f3_srl_sra: alu_sel = alt ? alu_sra : alu_srl;
      f3_or:      alu_sel = alu_or;
      default:    alu_sel = alu_and;
    endcase
  end

  always_comb begin
    use_rs1  = 1'b0;
    use_rs2  = 1'b0;
    wen      = 1'b0;
    a_is_pc  = 1'b0;
    b_is_imm = 1'b0;
    imm      = 32'h0;
    alu_op   = alu_add;
    br_cond  = br_none;
    case (opcode)
      op_lui: begin
        wen      = 1'b1;
        b_is_imm = 1'b1;
        imm      = imm_u(in.inst);
        alu_op   = alu_pass_b;
      end
      op_auipc: begin
        wen      = 1'b1;
        a_is_pc  = 1'b1;
        b_is_imm = 1'b1;
        imm      = imm_u(in.inst);
      end
      op_jal: begin
        wen     = 1'b1;
        a_is_pc = 1'b1; // target base
        imm     = imm_j(in.inst);
        br_cond = br_jump;
      end
      op_jalr: begin
        wen     = 1'b1;
        use_rs1 = 1'b1;
        imm     = imm_i(in.inst);
        br_cond = br_jump;
      end
      op_branch: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        imm     = imm_b(in.inst);
        case (funct3)
          f3_beq:  br_cond = br_eq;
          f3_bne:  br_cond = br_ne;
          f3_blt:  br_cond = br_lt;
          f3_bge:  br_cond = br_ge;
          f3_bltu: br_cond = br_ltu;
          f3_bgeu: br_cond = br_geu;
          default: br_cond = br_none;
        endcase
      end
      op_imm: begin
        wen      = 1'b1;
        use_rs1  = 1'b1;
        b_is_imm = 1'b1;
        imm      = imm_i(in.inst);
        alu_op   = alu_sel;
      end
      op_reg: begin
        wen     = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        alu_op  = alu_sel;
      end
      default: ; // unsupported opcodes pass as bubbles
    endcase
  end

  // rd check keeps a single writer per register in flight
  assign stall = (use_rs1 & busy[rs1_addr]) | (use_rs2 & busy[rs2_addr]) | (wen & busy[rd]);

  assign out_valid = in_valid & ~stall & ~flush;
  assign in_ready  = out_ready & ~stall;
  assign issue     = out_valid & out_ready;

  assign out = '{
    pc:         in.pc,
    op_a:       rs1_data,
    op_b:       rs2_data,
    imm:        imm,
    rd:         rd,
    wen:        wen,
    alu_op:     alu_op,
    br_cond:    br_cond,
    pred_taken: is_backward_branch(in.inst),
    a_is_pc:    a_is_pc,
    b_is_imm:   b_is_imm
  };

  always_ff @(posedge clock) begin
    if (reset) begin
      busy       <= 32'h0;
      last_valid <= 1'b0;
      last_rd    <= 5'd0;
    end else begin
      if (wb_valid) begin
        busy[wb_rd] <= 1'b0;
      end
      // the writer issued with the branch is wrong path and never writes
      if (flush & last_valid) begin
        busy[last_rd] <= 1'b0;
      end
      if (issue & wen & (rd != 5'd0)) begin
        busy[rd] <= 1'b1;
      end
      last_valid <= issue & wen & (rd != 5'd0);
      last_rd    <= rd;
    end
  end

endmodule

// File: src/execute_unit.sv
`timescale 1ns/1ps

module execute_unit import rv_isa_pkg::*, core_bus_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        in_valid,
  output logic        in_ready,
  input  issue_pkt_t  in,
  output logic        out_valid,
  output exec_pkt_t   out,
  output logic        flush,
  output logic [31:0] redirect_pc
);

  logic [31:0] a, b;
  logic [31:0] alu_res;
  logic [31:0] pc_plus4, target;
  logic [31:0] actual_pc, predict_pc;
  logic        jump, taken, accept;

  assign in_ready = ~flush; // item behind a flush is wrong path
  assign accept   = in_valid & in_ready;

  assign a = in.a_is_pc ? in.pc : in.op_a;
  assign b = in.b_is_imm ? in.imm : in.op_b;

  always_comb begin
    case (in.alu_op)
      alu_add:    alu_res = a + b;
      alu_sub:    alu_res = a - b;
      alu_sll:    alu_res = a << b[4:0];
      alu_slt:    alu_res = {31'h0, $signed(a) < $signed(b)};
      alu_sltu:   alu_res = {31'h0, a < b};
      alu_xor:    alu_res = a ^ b;
      alu_srl:    alu_res = a >> b[4:0];
      alu_sra:    alu_res = $signed(a) >>> b[4:0];
      alu_or:     alu_res = a | b;
      alu_and:    alu_res = a & b;
      alu_pass_b: alu_res = b;
      default:    alu_res = 32'h0;
    endcase
  end

  assign jump     = (in.br_cond == br_jump);
  assign pc_plus4 = in.pc + 32'd4;
  assign target   = ((jump ? a : in.pc) + in.imm) & ~32'h1; // jalr base is rs1

  always_comb begin
    case (in.br_cond)
      br_eq:   taken = (a == b);
      br_ne:   taken = (a != b);
      br_lt:   taken = ($signed(a) < $signed(b));
      br_ge:   taken = ($signed(a) >= $signed(b));
      br_ltu:  taken = (a < b);
      br_geu:  taken = (a >= b);
      br_jump: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  assign actual_pc  = taken ? target : pc_plus4;
  assign predict_pc = in.pred_taken ? target : pc_plus4;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
      flush     <= 1'b0;
    end else begin
      out_valid <= accept;
      flush     <= accept & (jump | (actual_pc != predict_pc));
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      out.pc      <= in.pc;
      out.value   <= jump ? pc_plus4 : alu_res; // link value
      out.rd      <= in.rd;
      out.wen     <= in.wen;
      redirect_pc <= actual_pc;
    end
  end

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import rv_isa_pkg::*, core_bus_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        flush,
  input  logic [31:0] redirect_pc,
  output logic        out_valid,
  input  logic        out_ready,
  output fetch_pkt_t  out,
  output axi_ar_t     mem_req,
  input  axi_r_t      mem_resp
);

  typedef enum logic [1:0] {
    st_request,
    st_wait_resp,
    st_hold
  } state_t;

  state_t      state, state_next;
  logic [31:0] pc, pc_next;
  logic [31:0] inst, inst_next;
  logic        discard, discard_next; // read in flight belongs to the old path
  logic        ar_fire, r_fire;
  logic [31:0] pc_step;

  assign ar_fire = (state == st_request) & mem_resp.arready;
  assign r_fire  = (state == st_wait_resp) & mem_resp.rvalid;
  assign pc_step = is_backward_branch(inst) ? imm_b(inst) : 32'd4;

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= st_request;
      pc      <= reset_pc;
      inst    <= nop_inst;
      discard <= 1'b0;
    end else begin
      state   <= state_next;
      pc      <= pc_next;
      inst    <= inst_next;
      discard <= discard_next;
    end
  end

  always_comb begin
    state_next   = state;
    pc_next      = pc;
    inst_next    = inst;
    discard_next = discard;
    case (state)
      st_request: begin
        if (ar_fire) begin
          state_next = st_wait_resp;
          if (flush) begin // old address already on the bus
            discard_next = 1'b1;
            pc_next      = redirect_pc;
          end
        end else if (flush) begin
          pc_next = redirect_pc; // retarget before handshake
        end
      end
      st_wait_resp: begin
        if (r_fire) begin
          if (flush) begin
            state_next   = st_request;
            discard_next = 1'b0;
            pc_next      = redirect_pc;
          end else if (discard) begin
            state_next   = st_request;
            discard_next = 1'b0;
          end else begin
            state_next = st_hold;
            inst_next  = pc[2] ? mem_resp.rdata[63:32] : mem_resp.rdata[31:0];
          end
        end else if (flush) begin
          discard_next = 1'b1;
          pc_next      = redirect_pc;
        end
      end
      st_hold: begin
        if (flush) begin
          state_next = st_request;
          pc_next    = redirect_pc;
        end else if (out_ready) begin
          state_next = st_request;
          pc_next    = pc + pc_step;
        end
      end
      default: state_next = st_request;
    endcase
  end

  assign out_valid = (state == st_hold) & ~flush;
  assign out       = '{pc: pc, inst: inst};

  assign mem_req = '{
    araddr:  pc,
    arvalid: (state == st_request),
    arid:    4'h0,
    arlen:   8'h00,  // single beat
    arsize:  3'b010, // 4 bytes
    arburst: 2'b00,
    rready:  (state == st_wait_resp)
  };

endmodule

// File: src/result_unit.sv
`timescale 1ns/1ps

module result_unit import core_bus_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        in_valid,
  input  exec_pkt_t   in,
  input  logic [4:0]  rs1_addr,
  input  logic [4:0]  rs2_addr,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  output logic        wb_valid,
  output logic [4:0]  wb_rd,
  output retire_t     retire,
  output logic        retire_valid
);

  logic [31:0] regs [1:31]; // x0 not stored
  logic        write;

  assign write = in_valid & in.wen & (in.rd != 5'd0);

  always_ff @(posedge clock) begin
    if (write) begin
      regs[in.rd] <= in.value;
    end
  end

  assign rs1_data = (rs1_addr == 5'd0) ? 32'h0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? 32'h0 : regs[rs2_addr];

  // frees the busy bit in decode
  assign wb_valid = write;
  assign wb_rd    = in.rd;

  always_ff @(posedge clock) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= in_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (in_valid) begin
      retire <= '{pc: in.pc, rd: in.rd, value: in.value, wen: in.wen};
    end
  end

endmodule

// File: src/rv_core.sv
`timescale 1ns/1ps

module rv_core import core_bus_pkg::*; (
  input  logic    clock,
  input  logic    reset,
  output axi_ar_t mem_req,
  input  axi_r_t  mem_resp,
  output retire_t retire,
  output logic    retire_valid
);

  fetch_pkt_t  fetch_pkt, decode_in;
  issue_pkt_t  issue_pkt, exec_in;
  exec_pkt_t   exec_out;
  logic        fetch_valid, fetch_ready;
  logic        decode_in_valid, decode_in_ready;
  logic        issue_valid, issue_ready;
  logic        exec_in_valid, exec_in_ready;
  logic        exec_out_valid;
  logic        flush;
  logic [31:0] redirect_pc;
  logic [4:0]  rs1_addr, rs2_addr;
  logic [31:0] rs1_data, rs2_data;
  logic        wb_valid;
  logic [4:0]  wb_rd;

  fetch_unit fetch (
    .clock, .reset, .flush, .redirect_pc,
    .out_valid (fetch_valid), .out_ready (fetch_ready), .out (fetch_pkt),
    .mem_req, .mem_resp
  );

  stage_reg #(.payload_t(fetch_pkt_t)) fetch_stage (
    .clock, .reset, .flush,
    .in_valid  (fetch_valid),     .in_ready  (fetch_ready),     .in  (fetch_pkt),
    .out_valid (decode_in_valid), .out_ready (decode_in_ready), .out (decode_in)
  );

  decode_unit decode (
    .clock, .reset, .flush,
    .in_valid  (decode_in_valid), .in_ready  (decode_in_ready), .in  (decode_in),
    .out_valid (issue_valid),     .out_ready (issue_ready),     .out (issue_pkt),
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data, .wb_valid, .wb_rd
  );

  stage_reg #(.payload_t(issue_pkt_t)) issue_stage (
    .clock, .reset, .flush,
    .in_valid  (issue_valid),   .in_ready  (issue_ready),   .in  (issue_pkt),
    .out_valid (exec_in_valid), .out_ready (exec_in_ready), .out (exec_in)
  );

  execute_unit execute (
    .clock, .reset,
    .in_valid  (exec_in_valid), .in_ready (exec_in_ready), .in (exec_in),
    .out_valid (exec_out_valid), .out (exec_out),
    .flush, .redirect_pc
  );

  result_unit result (
    .clock, .reset,
    .in_valid (exec_out_valid), .in (exec_out),
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .wb_valid, .wb_rd, .retire, .retire_valid
  );

endmodule

// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam logic [31:0] reset_pc = 32'h8000_0000;
  localparam logic [31:0] nop_inst = 32'h0000_0013; // addi x0, x0, 0

  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;

  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_t;

  typedef enum logic [2:0] {
    br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu, br_jump
  } br_cond_t;

  function automatic logic [31:0] imm_i(input logic [31:0] inst);
    return {{20{inst[31]}}, inst[31:20]};
  endfunction

  function automatic logic [31:0] imm_b(input logic [31:0] inst);
    return {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  endfunction

  function automatic logic [31:0] imm_u(input logic [31:0] inst);
    return {inst[31:12], 12'h000};
  endfunction

  function automatic logic [31:0] imm_j(input logic [31:0] inst);
    return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  endfunction

  // static prediction rule, shared by fetch and decode
  function automatic logic is_backward_branch(input logic [31:0] inst);
    return (inst[6:0] == op_branch) & inst[31];
  endfunction

endpackage

// File: src/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     flush,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out
);

  logic full;
  logic load;

  assign in_ready  = ~full | out_ready; // take new item as the old one leaves
  assign load      = in_valid & in_ready;
  assign out_valid = full;

  always_ff @(posedge clock) begin
    if (reset | flush) begin
      full <= 1'b0;
    end else if (load) begin
      full <= 1'b1;
    end else if (out_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      out <= in;
    end
  end

endmodule

// File: tb/axi_imem_model.sv
`timescale 1ns/1ps

module axi_imem_model import core_bus_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic [2:0] latency,
  input  axi_ar_t    req,
  output axi_r_t     resp
);

  logic [31:0] mem [0:255]; // one word per entry, base 0x80000000
  logic        busy = 1'b0;
  logic [2:0]  count = 3'd0;
  logic [7:0]  widx = 8'd0;
  logic [7:0]  even_idx;

  assign even_idx = {widx[7:1], 1'b0};

  assign resp = '{
    arready: ~busy,
    rvalid:  busy & (count == 3'd0),
    rdata:   {mem[even_idx + 8'd1], mem[even_idx]}, // 64-bit aligned pair
    rresp:   2'b00
  };

  always @(posedge clock) begin
    if (reset) begin
      busy  <= 1'b0;
      count <= 3'd0;
      widx  <= 8'd0;
    end else if (!busy) begin
      if (req.arvalid) begin
        busy  <= 1'b1;
        count <= latency;
        widx  <= req.araddr[9:2];
      end
    end else if (count != 3'd0) begin
      count <= count - 3'd1;
    end else if (req.rready) begin
      busy <= 1'b0;
    end
  end

endmodule

// File: tb/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
  input  logic restart,
  output logic clock,
  output logic reset
);

  logic [3:0] count = 4'd0; // reset cycles seen so far

  initial clock = 1'b0;
  always #10 clock = ~clock;

  always @(posedge clock) begin
    if (restart) begin
      count <= 4'd0;
    end else if (count != 4'd8) begin
      count <= count + 4'd1;
    end
  end

  assign reset = (count != 4'd8);

endmodule

// File: tb/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb import rv_isa_pkg::*, core_bus_pkg::*;;

  localparam int unsigned total_retires = 68;
  localparam int unsigned max_latency   = 5;
  localparam int unsigned n_tests       = 6;
  localparam int unsigned timeout_cycles =
    (total_retires * (max_latency + 10) + n_tests * 20) * 3;

  logic        clock, reset, restart;
  axi_ar_t     mem_req;
  axi_r_t      mem_resp;
  retire_t     retire;
  logic        retire_valid;
  logic        random_lat;
  logic [2:0]  fixed_lat;
  logic [2:0]  latency;
  logic [2:0]  lat_seq [0:511];
  logic [8:0]  lat_idx;

  logic [31:0] prog[$];
  logic [31:0] exp_pc[$], exp_val[$], got_pc[$], got_val[$];
  logic [4:0]  exp_rd[$], got_rd[$];
  logic        exp_wen[$], got_wen[$];
  logic [31:0] end_pc;
  int          errors;
  int          run_start_errors;
  int          test_count;

  clock_gen clkgen (.restart, .clock, .reset);

  axi_imem_model imem (.clock, .reset, .latency, .req(mem_req), .resp(mem_resp));

  rv_core uut (.clock, .reset, .mem_req, .mem_resp, .retire, .retire_valid);

  // one latency value per accepted read request
  always @(posedge clock) begin
    if (reset) begin
      lat_idx <= 9'd0;
    end else if (mem_req.arvalid & mem_resp.arready) begin
      lat_idx <= lat_idx + 9'd1;
    end
  end

  assign latency = random_lat ? lat_seq[lat_idx] : fixed_lat;

  // every read is a single 4-byte beat
  always @(negedge clock) begin
    if (!reset && mem_req.arvalid && mem_resp.arready) begin
      check_value("mem_req.arlen", 32'(mem_req.arlen), 32'h0);
      check_value("mem_req.arsize", 32'(mem_req.arsize), 32'h2);
    end
  end

  function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] encode_i(input logic [6:0] op, input logic [11:0] imm,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encode_b(input logic [12:0] off, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
  endfunction

  function automatic logic [31:0] encode_u(input logic [6:0] op, input logic [19:0] imm,
      input logic [4:0] rd);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] encode_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
  endfunction

  task automatic emit(input logic [31:0] inst);
    prog.push_back(inst);
  endtask

  // self loop closes each program
  task automatic emit_end();
    end_pc = reset_pc + 32'(prog.size() * 4);
    prog.push_back(encode_j(21'd0, 5'd0));
    expect_retire(end_pc - reset_pc, 1'b1, 5'd0, end_pc + 32'd4);
  endtask

  task automatic expect_retire(input logic [31:0] off, input logic wen, input logic [4:0] rd,
      input logic [31:0] value);
    exp_pc.push_back(reset_pc + off);
    exp_wen.push_back(wen);
    exp_rd.push_back(rd);
    exp_val.push_back(value);
  endtask

  task automatic clear_lists();
    prog.delete();
    exp_pc.delete();
    exp_wen.delete();
    exp_rd.delete();
    exp_val.delete();
    got_pc.delete();
    got_wen.delete();
    got_rd.delete();
    got_val.delete();
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
      input logic [31:0] expected);
    if (got !== expected) begin
      $display("MISMATCH %s: got %h expected %h", name, got, expected);
      errors++;
    end
  endtask

  task automatic run_program(input logic use_random);
    run_start_errors = errors;
    @(posedge clock);
    restart    <= 1'b1;
    random_lat <= use_random;
    @(posedge clock);
    restart <= 1'b0;
    @(negedge clock);
    // spare words hold addi x0 tagged with their index
    for (int i = 0; i < 256; i++) begin
      imem.mem[i] = (i < prog.size()) ? prog[i]
                                      : encode_i(op_imm, 12'(i), 5'd0, f3_add_sub, 5'd0);
    end
    while (reset) @(negedge clock);
    forever begin
      @(negedge clock);
      if (retire_valid) begin
        got_pc.push_back(retire.pc);
        got_wen.push_back(retire.wen);
        got_rd.push_back(retire.rd);
        got_val.push_back(retire.value);
        if (retire.pc == end_pc) break;
      end
    end
  endtask

  task automatic compare_trace(input string test_name);
    int n;
    n = (got_pc.size() < exp_pc.size()) ? got_pc.size() : exp_pc.size();
    if (got_pc.size() != exp_pc.size()) begin
      $display("%s: %0d instructions retired where %0d were expected",
               test_name, got_pc.size(), exp_pc.size());
      errors++;
    end
    for (int i = 0; i < n; i++) begin
      check_value("retire.pc", got_pc[i], exp_pc[i]);
      check_value("retire.wen", 32'(got_wen[i]), 32'(exp_wen[i]));
      if (exp_wen[i]) begin
        check_value("retire.rd", 32'(got_rd[i]), 32'(exp_rd[i]));
        check_value("retire.value", got_val[i], exp_val[i]);
      end
    end
    test_count++;
    $display("test %s: %s (%0d errors)", test_name,
             (errors == run_start_errors) ? "ok" : "failed", errors - run_start_errors);
  endtask

  task automatic test_alu();
    clear_lists();
    emit(encode_i(op_imm, 12'h123, 5'd0, f3_add_sub, 5'd1));
    emit(encode_i(op_imm, 12'hffb, 5'd0, f3_add_sub, 5'd2));
    emit(encode_r(7'h00, 5'd2, 5'd1, f3_add_sub, 5'd3));
    emit(encode_r(7'h20, 5'd2, 5'd1, f3_add_sub, 5'd4));
    emit(encode_i(op_imm, 12'h004, 5'd1, f3_sll, 5'd5));
    emit(encode_r(7'h00, 5'd1, 5'd1, f3_sll, 5'd6));     // shamt 3
    emit(encode_r(7'h00, 5'd1, 5'd2, f3_slt, 5'd7));
    emit(encode_r(7'h00, 5'd1, 5'd2, f3_sltu, 5'd8));
    emit(encode_i(op_imm, 12'hfff, 5'd1, f3_slt, 5'd9));
    emit(encode_i(op_imm, 12'hfff, 5'd1, f3_sltu, 5'd10));
    emit(encode_r(7'h00, 5'd2, 5'd1, f3_xor, 5'd11));
    emit(encode_i(op_imm, 12'h0ff, 5'd1, f3_xor, 5'd12));
    emit(encode_i(op_imm, 12'h004, 5'd2, f3_srl_sra, 5'd13));
    emit(encode_i(op_imm, 12'h401, 5'd2, f3_srl_sra, 5'd14));
    emit(encode_r(7'h20, 5'd1, 5'd2, f3_srl_sra, 5'd15));
    emit(encode_r(7'h00, 5'd1, 5'd2, f3_srl_sra, 5'd16));
    emit(encode_r(7'h00, 5'd2, 5'd1, f3_or, 5'd17));
    emit(encode_i(op_imm, 12'h400, 5'd1, f3_or, 5'd18));
    emit(encode_r(7'h00, 5'd2, 5'd1, f3_and, 5'd19));
    emit(encode_i(op_imm, 12'h0f0, 5'd2, f3_and, 5'd20));
    emit(encode_i(op_imm, 12'h005, 5'd1, f3_add_sub, 5'd0));
    emit(encode_r(7'h00, 5'd0, 5'd0, f3_add_sub, 5'd21));
    expect_retire(32'h00, 1'b1, 5'd1, 32'h0000_0123);
    expect_retire(32'h04, 1'b1, 5'd2, 32'hffff_fffb);
    expect_retire(32'h08, 1'b1, 5'd3, 32'h0000_011e);
    expect_retire(32'h0c, 1'b1, 5'd4, 32'h0000_0128);
    expect_retire(32'h10, 1'b1, 5'd5, 32'h0000_1230);
    expect_retire(32'h14, 1'b1, 5'd6, 32'h0000_0918);
    expect_retire(32'h18, 1'b1, 5'd7, 32'h0000_0001);
    expect_retire(32'h1c, 1'b1, 5'd8, 32'h0000_0000);
    expect_retire(32'h20, 1'b1, 5'd9, 32'h0000_0000);
    expect_retire(32'h24, 1'b1, 5'd10, 32'h0000_0001);
    expect_retire(32'h28, 1'b1, 5'd11, 32'hffff_fed8);
    expect_retire(32'h2c, 1'b1, 5'd12, 32'h0000_01dc);
    expect_retire(32'h30, 1'b1, 5'd13, 32'h0fff_ffff);
    expect_retire(32'h34, 1'b1, 5'd14, 32'hffff_fffd);
    expect_retire(32'h38, 1'b1, 5'd15, 32'hffff_ffff);
    expect_retire(32'h3c, 1'b1, 5'd16, 32'h1fff_ffff);
    expect_retire(32'h40, 1'b1, 5'd17, 32'hffff_fffb);
    expect_retire(32'h44, 1'b1, 5'd18, 32'h0000_0523);
    expect_retire(32'h48, 1'b1, 5'd19, 32'h0000_0123);
    expect_retire(32'h4c, 1'b1, 5'd20, 32'h0000_00f0);
    expect_retire(32'h50, 1'b1, 5'd0, 32'h0000_0128); // x0 write still retires
    expect_retire(32'h54, 1'b1, 5'd21, 32'h0000_0000);
    emit_end();
    run_program(1'b0);
    compare_trace("alu");
  endtask

  task automatic test_dependent();
    clear_lists();
    emit(encode_i(op_imm, 12'h001, 5'd0, f3_add_sub, 5'd1));
    emit(encode_r(7'h00, 5'd1, 5'd1, f3_add_sub, 5'd1));
    emit(encode_i(op_imm, 12'h003, 5'd1, f3_add_sub, 5'd1));
    emit(encode_i(op_imm, 12'h002, 5'd1, f3_sll, 5'd1));
    emit(encode_r(7'h20, 5'd1, 5'd0, f3_add_sub, 5'd2));
    emit(encode_r(7'h00, 5'd1, 5'd2, f3_xor, 5'd3));
    expect_retire(32'h00, 1'b1, 5'd1, 32'h0000_0001);
    expect_retire(32'h04, 1'b1, 5'd1, 32'h0000_0002);
    expect_retire(32'h08, 1'b1, 5'd1, 32'h0000_0005);
    expect_retire(32'h0c, 1'b1, 5'd1, 32'h0000_0014);
    expect_retire(32'h10, 1'b1, 5'd2, 32'hffff_ffec);
    expect_retire(32'h14, 1'b1, 5'd3, 32'hffff_fff8);
    emit_end();
    run_program(1'b0);
    compare_trace("dependent");
  endtask

  task automatic test_forward_branch();
    clear_lists();
    emit(encode_i(op_imm, 12'h007, 5'd0, f3_add_sub, 5'd1));
    emit(encode_i(op_imm, 12'h007, 5'd0, f3_add_sub, 5'd2));
    emit(encode_b(13'd12, 5'd2, 5'd1, f3_beq));
    emit(encode_i(op_imm, 12'h001, 5'd0, f3_add_sub, 5'd3)); // wrong path
    emit(encode_i(op_imm, 12'h002, 5'd0, f3_add_sub, 5'd3)); // wrong path
    emit(encode_i(op_imm, 12'h001, 5'd1, f3_add_sub, 5'd4));
    expect_retire(32'h00, 1'b1, 5'd1, 32'h0000_0007);
    expect_retire(32'h04, 1'b1, 5'd2, 32'h0000_0007);
    expect_retire(32'h08, 1'b0, 5'd0, 32'h0);
    expect_retire(32'h14, 1'b1, 5'd4, 32'h0000_0008);
    emit_end();
    run_program(1'b0);
    compare_trace("forward_branch");
  endtask

  task automatic test_loop(input logic use_random, input string test_name);
    clear_lists();
    emit(encode_i(op_imm, 12'h003, 5'd0, f3_add_sub, 5'd1));
    emit(encode_i(op_imm, 12'h000, 5'd0, f3_add_sub, 5'd2));
    emit(encode_i(op_imm, 12'h005, 5'd2, f3_add_sub, 5'd2));
    emit(encode_i(op_imm, 12'hfff, 5'd1, f3_add_sub, 5'd1));
    emit(encode_b(-13'sd8, 5'd0, 5'd1, f3_bne));
    emit(encode_i(op_imm, 12'h010, 5'd1, f3_add_sub, 5'd3));
    expect_retire(32'h00, 1'b1, 5'd1, 32'd3);
    expect_retire(32'h04, 1'b1, 5'd2, 32'd0);
    for (int k = 1; k <= 3; k++) begin
      expect_retire(32'h08, 1'b1, 5'd2, 32'(5 * k));
      expect_retire(32'h0c, 1'b1, 5'd1, 32'(3 - k));
      expect_retire(32'h10, 1'b0, 5'd0, 32'h0);
    end
    expect_retire(32'h14, 1'b1, 5'd3, 32'h0000_0010); // counter reached zero
    emit_end();
    run_program(use_random);
    compare_trace(test_name);
  endtask

  task automatic test_jumps();
    clear_lists();
    emit(encode_u(op_lui, 20'h12345, 5'd1));
    emit(encode_u(op_auipc, 20'h00001, 5'd2));
    emit(encode_j(21'd12, 5'd3));
    emit(encode_i(op_imm, 12'h001, 5'd0, f3_add_sub, 5'd5)); // wrong path
    emit(encode_i(op_imm, 12'h002, 5'd0, f3_add_sub, 5'd5)); // wrong path
    emit(encode_u(op_auipc, 20'h00000, 5'd4));
    emit(encode_i(op_jalr, 12'h00c, 5'd4, 3'b000, 5'd6));
    emit(encode_i(op_imm, 12'h003, 5'd0, f3_add_sub, 5'd5)); // wrong path
    emit(encode_i(op_imm, 12'h000, 5'd3, f3_add_sub, 5'd7));
    expect_retire(32'h00, 1'b1, 5'd1, 32'h1234_5000);
    expect_retire(32'h04, 1'b1, 5'd2, 32'h8000_1004);
    expect_retire(32'h08, 1'b1, 5'd3, 32'h8000_000c);
    expect_retire(32'h14, 1'b1, 5'd4, 32'h8000_0014);
    expect_retire(32'h18, 1'b1, 5'd6, 32'h8000_001c);
    expect_retire(32'h20, 1'b1, 5'd7, 32'h8000_000c);
    emit_end();
    run_program(1'b0);
    compare_trace("jumps");
  endtask

  initial begin
    restart    = 1'b0;
    random_lat = 1'b0;
    fixed_lat  = 3'd2;
    errors     = 0;
    test_count = 0;
    void'($urandom(26));
    for (int i = 0; i < 512; i++) begin
      lat_seq[i] = 3'($urandom_range(max_latency, 0));
    end
    test_alu();
    test_dependent();
    test_forward_branch();
    test_loop(1'b0, "loop");
    test_jumps();
    test_loop(1'b1, "loop_random_latency");
    $display("%0d tests run, %0d errors", test_count, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(timeout_cycles * 20);
    $display("timeout: the end of a test program never retired");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule
